/* mipsCore.f */
src/mipsPkg.sv
src/fetchUnit.sv
src/controlUnit.sv
src/registerFile.sv
src/aluUnit.sv
src/dataAccess.sv
src/mipsCore.sv
dv/mipsModel.sv
dv/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the output
verilator --binary -Wno-fatal --top-module mipsCoreTb -f mipsCore.f \
  && ./obj_dir/VmipsCoreTb | tee /dev/stderr | grep -qF '** PASS **' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* dv/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb;

  logic            clk;
  logic            rstN;
  mipsPkg::word_t  iAddr;
  mipsPkg::instr_t iLoad;
  logic            iHit;
  mipsPkg::word_t  dAddr;
  mipsPkg::word_t  dStore;
  logic            dRen;
  logic            dWen;
  mipsPkg::word_t  dLoad;
  logic            dHit;
  logic            halt;

  mipsPkg::word_t respMem [mipsModel::DATA_DEPTH];  // Data memory behind the DUT
  int             storesSeen;

  mipsCore dut_i (
    .clk    (clk),
    .rstN   (rstN),
    .iAddr  (iAddr),
    .iLoad  (iLoad),
    .iHit   (iHit),
    .dAddr  (dAddr),
    .dStore (dStore),
    .dRen   (dRen),
    .dWen   (dWen),
    .dLoad  (dLoad),
    .dHit   (dHit),
    .halt   (halt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stopWithError(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic checkWord(input string name, input mipsPkg::word_t expected,
                           input mipsPkg::word_t actual);
    if (actual !== expected)
      stopWithError($sformatf("mismatch at %0d ns: %s expected %h, got %h",
                              $time, name, expected, actual));
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      stopWithError($sformatf("mismatch at %0d ns: %s expected %b, got %b",
                              $time, name, expected, actual));
  endtask

  // Outputs while the current instruction is pending
  task automatic compareOutputs(input mipsPkg::word_t curPc);
    checkWord("iAddr", curPc, iAddr);
    checkFlag("halt", 1'b0, halt);
    checkFlag("dRen", mipsModel::isLoad && iHit, dRen);
    checkFlag("dWen", mipsModel::isStore && iHit, dWen);
    if (iHit && (mipsModel::isLoad || mipsModel::isStore))
      checkWord("dAddr", mipsModel::accAddr, dAddr);
    if (iHit && mipsModel::isStore)
      checkWord("dStore", mipsModel::accStore, dStore);
  endtask

  // Starts on a falling edge and returns on the falling edge after retire
  task automatic executeInstr();
    mipsPkg::word_t curPc;
    int             delay;
    int             idx;
    curPc = mipsModel::pc;
    mipsModel::stepModel();
    delay = $urandom_range(0, 3);
    repeat (delay) begin  // Fetch still outstanding
      iHit = 1'b0;
      #10;
      compareOutputs(curPc);
      @(negedge clk);
    end
    iHit  = 1'b1;
    iLoad = mipsModel::fetchWord(iAddr);
    #10;
    compareOutputs(curPc);
    if (dRen || dWen) begin
      delay = $urandom_range(0, 3);
      repeat (delay) begin
        @(negedge clk);
        #10;
        compareOutputs(curPc);  // Request must hold without dHit
      end
      @(negedge clk);
      idx = mipsModel::dataIndex(dAddr);
      if (idx < 0)
        stopWithError($sformatf("data access outside the data array at address %h", dAddr));
      dHit = 1'b1;
      if (dWen) begin
        respMem[idx] = dStore;
        storesSeen++;
      end else begin
        dLoad = respMem[idx];
      end
    end
    @(negedge clk);
    iHit = 1'b0;
    dHit = 1'b0;
  endtask

  initial begin
    int steps;
    rstN       = 1'b0;
    iHit       = 1'b0;
    dHit       = 1'b0;
    iLoad      = '0;
    dLoad      = '0;
    storesSeen = 0;
    void'($urandom(mipsModel::SEED));
    mipsModel::genProgram();
    mipsModel::resetModel();
    foreach (respMem[k])
      respMem[k] = mipsModel::fillWord(k);
    repeat (4) @(negedge clk);
    rstN = 1'b1;

    steps = 0;
    while (!mipsModel::isHalt && steps < mipsModel::MAX_STEPS) begin
      executeInstr();
      steps++;
    end
    if (!mipsModel::isHalt)
      stopWithError("program did not reach HALT within the step limit");

    steps = 0;
    while (halt !== 1'b1 && steps < mipsModel::TIMEOUT) begin
      @(negedge clk);
      steps++;
    end
    if (halt !== 1'b1)
      stopWithError("timed out waiting for halt to rise after HALT retired");

    // Halted core ignores the HALT word still on the bus
    iHit = 1'b1;
    repeat (3) begin
      @(negedge clk);
      #10;
      checkWord("iAddr", mipsModel::pc, iAddr);
      checkFlag("dWen", 1'b0, dWen);
      checkFlag("halt", 1'b1, halt);
    end

    checkWord("storeCount", mipsPkg::word_t'(mipsModel::storeCount),
              mipsPkg::word_t'(storesSeen));
    $display("** PASS **");
    $finish;
  end

endmodule

/* dv/mipsModel.sv */
package mipsModel;

  localparam int             SEED       = 53753;
  localparam int             IMEM_DEPTH = 256;  // Indexed by address bits 9:2
  localparam int             PROG_LEN   = 160;
  localparam int             DATA_DEPTH = 64;
  localparam mipsPkg::word_t DATA_BASE  = 32'h0000_4000;
  localparam int             MAX_STEPS  = 400;
  localparam int             TIMEOUT    = 20;

  localparam mipsPkg::funct_t R_OPS [12] = '{
    mipsPkg::ADD, mipsPkg::ADDU, mipsPkg::SUB, mipsPkg::SUBU, mipsPkg::AND, mipsPkg::OR,
    mipsPkg::XOR, mipsPkg::NOR, mipsPkg::SLT, mipsPkg::SLTU, mipsPkg::SLL, mipsPkg::SRL
  };
  localparam mipsPkg::opcode_t I_OPS [8] = '{
    mipsPkg::ADDI, mipsPkg::ADDIU, mipsPkg::SLTI, mipsPkg::SLTIU,
    mipsPkg::ANDI, mipsPkg::ORI, mipsPkg::XORI, mipsPkg::LUI
  };

  mipsPkg::instr_t imem [IMEM_DEPTH];  // Shared program image
  mipsPkg::word_t  regs [32];
  mipsPkg::word_t  dataMem [DATA_DEPTH];
  mipsPkg::word_t  pc;
  int              storeCount;

  // Data access of the instruction stepped last
  mipsPkg::word_t  accAddr;
  mipsPkg::word_t  accStore;
  bit              isLoad;
  bit              isStore;
  bit              isHalt;

  // Initial data word hashed from the full byte address
  function automatic mipsPkg::word_t fillWord(int idx);
    mipsPkg::word_t addr;
    addr = DATA_BASE + mipsPkg::word_t'(idx) * 32'd4;
    return (addr * 32'h9E37_79B9) ^ {addr[15:0], ~addr[15:0]};
  endfunction

  function automatic int dataIndex(mipsPkg::word_t addr);
    mipsPkg::word_t off;
    off = addr - DATA_BASE;
    if (off[1:0] != 2'b00 || off >= mipsPkg::word_t'(DATA_DEPTH * 4))
      return -1;
    return int'(off >> 2);
  endfunction

  function automatic mipsPkg::instr_t fetchWord(mipsPkg::word_t addr);
    return imem[addr[9:2]];
  endfunction

  function automatic mipsPkg::instr_t makeR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                            logic [4:0] shamt, mipsPkg::funct_t funct);
    mipsPkg::instr_t ins;
    ins.r.opcode = mipsPkg::RTYPE;
    ins.r.rs     = rs;
    ins.r.rt     = rt;
    ins.r.rd     = rd;
    ins.r.shamt  = shamt;
    ins.r.funct  = funct;
    return ins;
  endfunction

  function automatic mipsPkg::instr_t makeI(mipsPkg::opcode_t op, logic [4:0] rs,
                                            logic [4:0] rt, logic [15:0] imm);
    mipsPkg::instr_t ins;
    ins.i.opcode = op;
    ins.i.rs     = rs;
    ins.i.rt     = rt;
    ins.i.imm    = imm;
    return ins;
  endfunction

  // Random program with forward-only control flow and HALT at the end
  function automatic void genProgram();
    bit              isTarget [IMEM_DEPTH];
    mipsPkg::instr_t ins;
    int              p;
    int              kind;
    int              t;
    logic [4:0]      rs;
    for (int a = 0; a < IMEM_DEPTH; a++)
      imem[a] = makeI(mipsPkg::HALT, 5'd0, 5'd0, 16'h0000);
    p = 0;
    while (p < PROG_LEN - 1) begin
      kind = $urandom_range(0, 9);
      rs   = 5'($urandom_range(0, 31));
      if (kind == 9 && p + 3 < PROG_LEN - 1 && !isTarget[p + 1] && !isTarget[p + 2]) begin
        // LUI/ORI build the JR target in r30
        t = $urandom_range(p + 3, PROG_LEN - 1);
        isTarget[t] = 1'b1;
        imem[p]     = makeI(mipsPkg::LUI, 5'd0, 5'd30, 16'((t * 4) >> 16));
        imem[p + 1] = makeI(mipsPkg::ORI, 5'd30, 5'd30, 16'(t * 4));
        imem[p + 2] = makeR(5'd30, 5'd0, 5'd0, 5'd0, mipsPkg::JR);
        p += 3;
      end else begin
        case (kind)
          0, 1, 2: ins = makeR(rs, 5'($urandom_range(0, 31)), 5'($urandom_range(1, 29)),
                               5'($urandom_range(0, 31)), R_OPS[$urandom_range(0, 11)]);
          5: ins = makeI(mipsPkg::LW, 5'd0, 5'($urandom_range(1, 29)),
                         16'(DATA_BASE + 4 * $urandom_range(0, DATA_DEPTH - 1)));
          6: ins = makeI(mipsPkg::SW, 5'd0, 5'($urandom_range(0, 31)),
                         16'(DATA_BASE + 4 * $urandom_range(0, DATA_DEPTH - 1)));
          7: begin
            t = p + 1 + $urandom_range(0, 3);
            if (t > PROG_LEN - 1)
              t = PROG_LEN - 1;
            isTarget[t] = 1'b1;
            ins = makeI(($urandom_range(0, 1) == 0) ? mipsPkg::BEQ : mipsPkg::BNE, rs,
                        ($urandom_range(0, 2) == 0) ? rs : 5'($urandom_range(0, 31)),
                        16'(t - p - 1));  // Equal operands now and then
          end
          8: begin
            t = p + 1 + $urandom_range(0, 7);
            if (t > PROG_LEN - 1)
              t = PROG_LEN - 1;
            isTarget[t] = 1'b1;
            ins          = '0;
            ins.j.opcode = ($urandom_range(0, 1) == 0) ? mipsPkg::J : mipsPkg::JAL;
            ins.j.addr   = 26'(t);
          end
          default: ins = makeI(I_OPS[$urandom_range(0, 7)], rs, 5'($urandom_range(1, 29)),
                               16'($urandom()));
        endcase
        imem[p] = ins;
        p++;
      end
    end
  endfunction

  function automatic void resetModel();
    foreach (regs[k])
      regs[k] = '0;
    foreach (dataMem[k])
      dataMem[k] = fillWord(k);
    pc         = mipsPkg::RESET_PC;
    storeCount = 0;
    isLoad     = 1'b0;
    isStore    = 1'b0;
    isHalt     = 1'b0;
  endfunction

  // Executes one instruction at pc as the ISA defines it
  function automatic void stepModel();
    mipsPkg::instr_t ins;
    mipsPkg::word_t  rsVal;
    mipsPkg::word_t  rtVal;
    mipsPkg::word_t  sImm;
    mipsPkg::word_t  zImm;
    mipsPkg::word_t  result;
    mipsPkg::word_t  nextPc;
    logic [4:0]      dst;
    bit              write;
    ins     = fetchWord(pc);
    rsVal   = regs[ins.r.rs];
    rtVal   = regs[ins.r.rt];
    sImm    = {{16{ins.i.imm[15]}}, ins.i.imm};
    zImm    = {16'h0000, ins.i.imm};
    nextPc  = pc + 32'd4;
    dst     = ins.i.rt;
    write   = 1'b1;
    result  = '0;
    isLoad  = 1'b0;
    isStore = 1'b0;
    isHalt  = 1'b0;
    case (ins.r.opcode)
      mipsPkg::RTYPE: begin
        dst = ins.r.rd;
        case (ins.r.funct)
          mipsPkg::SLL:                result = rtVal << ins.r.shamt;
          mipsPkg::SRL:                result = rtVal >> ins.r.shamt;
          mipsPkg::ADD, mipsPkg::ADDU: result = rsVal + rtVal;
          mipsPkg::SUB, mipsPkg::SUBU: result = rsVal - rtVal;
          mipsPkg::AND:                result = rsVal & rtVal;
          mipsPkg::OR:                 result = rsVal | rtVal;
          mipsPkg::XOR:                result = rsVal ^ rtVal;
          mipsPkg::NOR:                result = ~(rsVal | rtVal);
          mipsPkg::SLT:  result = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
          mipsPkg::SLTU: result = (rsVal < rtVal) ? 32'd1 : 32'd0;
          mipsPkg::JR: begin
            write  = 1'b0;
            nextPc = rsVal;
          end
          default: write = 1'b0;
        endcase
      end
      mipsPkg::ADDI, mipsPkg::ADDIU: result = rsVal + sImm;
      mipsPkg::SLTI:  result = ($signed(rsVal) < $signed(sImm)) ? 32'd1 : 32'd0;
      mipsPkg::SLTIU: result = (rsVal < sImm) ? 32'd1 : 32'd0;
      mipsPkg::ANDI:  result = rsVal & zImm;
      mipsPkg::ORI:   result = rsVal | zImm;
      mipsPkg::XORI:  result = rsVal ^ zImm;
      mipsPkg::LUI:   result = {ins.i.imm, 16'h0000};
      mipsPkg::LW: begin
        isLoad  = 1'b1;
        accAddr = rsVal + sImm;
        result  = dataMem[dataIndex(accAddr)];
      end
      mipsPkg::SW: begin
        write    = 1'b0;
        isStore  = 1'b1;
        accAddr  = rsVal + sImm;
        accStore = rtVal;
        dataMem[dataIndex(accAddr)] = rtVal;
        storeCount++;
      end
      mipsPkg::BEQ, mipsPkg::BNE: begin
        write = 1'b0;
        if ((rsVal == rtVal) == (ins.i.opcode == mipsPkg::BEQ))
          nextPc = nextPc + (sImm << 2);
      end
      mipsPkg::J: begin
        write  = 1'b0;
        nextPc = {nextPc[31:28], ins.j.addr, 2'b00};
      end
      mipsPkg::JAL: begin
        dst    = mipsPkg::LINK_REG;
        result = nextPc;  // Return address
        nextPc = {nextPc[31:28], ins.j.addr, 2'b00};
      end
      mipsPkg::HALT: begin
        write  = 1'b0;
        isHalt = 1'b1;
        nextPc = pc;
      end
      default: write = 1'b0;
    endcase
    if (write && dst != 5'd0)
      regs[dst] = result;
    pc = nextPc;
  endfunction

endpackage

/* src/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore (
  input  logic            clk,
  input  logic            rstN,
  output mipsPkg::word_t  iAddr,
  input  mipsPkg::instr_t iLoad,
  input  logic            iHit,
  output mipsPkg::word_t  dAddr,
  output mipsPkg::word_t  dStore,
  output logic            dRen,
  output logic            dWen,
  input  mipsPkg::word_t  dLoad,
  input  logic            dHit,
  output logic            halt
);

  mipsPkg::ctrl_t ctrl;
  mipsPkg::word_t pc;
  mipsPkg::word_t pcPlus4;
  mipsPkg::word_t rsData;
  mipsPkg::word_t rtData;
  mipsPkg::word_t aluOut;
  mipsPkg::word_t wrData;
  logic [4:0]     wrSel;
  logic           zero;

  assign iAddr = pc;

  fetchUnit fetch_i (
    .clk     (clk),
    .rstN    (rstN),
    .iHit    (iHit),
    .dHit    (dHit),
    .ctrl    (ctrl),
    .instr   (iLoad),
    .rsData  (rsData),
    .zero    (zero),
    .pc      (pc),
    .pcPlus4 (pcPlus4),
    .halt    (halt)
  );

  controlUnit control_i (
    .instr (iLoad),
    .iHit  (iHit),
    .dHit  (dHit),
    .ctrl  (ctrl)
  );

  // rs on port 1, rt on port 2
  registerFile regFile_i (
    .clk   (clk),
    .rstN  (rstN),
    .wen   (ctrl.wen),
    .wsel  (wrSel),
    .wdat  (wrData),
    .rsel1 (iLoad.r.rs),
    .rsel2 (iLoad.r.rt),
    .rdat1 (rsData),
    .rdat2 (rtData)
  );

  aluUnit alu_i (
    .ctrl   (ctrl),
    .instr  (iLoad),
    .rsData (rsData),
    .rtData (rtData),
    .aluOut (aluOut),
    .zero   (zero)
  );

  dataAccess data_i (
    .ctrl    (ctrl),
    .aluOut  (aluOut),
    .rtData  (rtData),
    .dLoad   (dLoad),
    .pcPlus4 (pcPlus4),
    .instr   (iLoad),
    .dAddr   (dAddr),
    .dStore  (dStore),
    .dRen    (dRen),
    .dWen    (dWen),
    .wrData  (wrData),
    .wrSel   (wrSel)
  );

endmodule

/* src/dataAccess.sv */
`timescale 1ns/1ps

module dataAccess (
  input  mipsPkg::ctrl_t  ctrl,
  input  mipsPkg::word_t  aluOut,
  input  mipsPkg::word_t  rtData,
  input  mipsPkg::word_t  dLoad,
  input  mipsPkg::word_t  pcPlus4,
  input  mipsPkg::instr_t instr,
  output mipsPkg::word_t  dAddr,
  output mipsPkg::word_t  dStore,
  output logic            dRen,
  output logic            dWen,
  output mipsPkg::word_t  wrData,
  output logic [4:0]      wrSel
);

  assign dAddr  = aluOut;  // Base plus offset
  assign dStore = rtData;
  assign dRen   = ctrl.dRen;
  assign dWen   = ctrl.dWen;

  always_comb begin
    if (ctrl.jl)
      wrData = pcPlus4;  // Return address
    else if (ctrl.lui)
      wrData = {instr.i.imm, 16'h0000};
    else if (ctrl.memToReg)
      wrData = dLoad;
    else
      wrData = aluOut;
  end

  // Destination register
  always_comb begin
    if (ctrl.jl)
      wrSel = mipsPkg::LINK_REG;
    else
      wrSel = ctrl.regDst ? instr.r.rd : instr.i.rt;
  end

endmodule

/* src/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
  input  mipsPkg::ctrl_t  ctrl,
  input  mipsPkg::instr_t instr,
  input  mipsPkg::word_t  rsData,
  input  mipsPkg::word_t  rtData,
  output mipsPkg::word_t  aluOut,
  output logic            zero
);

  mipsPkg::word_t imm32;
  mipsPkg::word_t opA;
  mipsPkg::word_t opB;

  assign imm32 = ctrl.zeroExt ? {16'h0000, instr.i.imm}
                              : {{16{instr.i.imm[15]}}, instr.i.imm};

  // Shifts work on rt by shamt
  assign opA = ctrl.shiftSel ? rtData : rsData;

  always_comb begin
    if (ctrl.shiftSel)
      opB = {27'd0, instr.r.shamt};
    else if (ctrl.aluSrc)
      opB = imm32;
    else
      opB = rtData;
  end

  always_comb begin
    case (ctrl.aluOp)
      mipsPkg::ALU_SLL:  aluOut = opA << opB[4:0];
      mipsPkg::ALU_SRL:  aluOut = opA >> opB[4:0];
      mipsPkg::ALU_ADD:  aluOut = opA + opB;
      mipsPkg::ALU_SUB:  aluOut = opA - opB;
      mipsPkg::ALU_AND:  aluOut = opA & opB;
      mipsPkg::ALU_OR:   aluOut = opA | opB;
      mipsPkg::ALU_XOR:  aluOut = opA ^ opB;
      mipsPkg::ALU_NOR:  aluOut = ~(opA | opB);
      mipsPkg::ALU_SLT:  aluOut = {31'd0, $signed(opA) < $signed(opB)};
      mipsPkg::ALU_SLTU: aluOut = {31'd0, opA < opB};
      default:           aluOut = '0;
    endcase
  end

  assign zero = (aluOut == '0);  // Branch compare result

endmodule

/* src/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
  input  logic           clk,
  input  logic           rstN,
  input  logic           wen,
  input  logic [4:0]     wsel,
  input  mipsPkg::word_t wdat,
  input  logic [4:0]     rsel1,
  input  logic [4:0]     rsel2,
  output mipsPkg::word_t rdat1,
  output mipsPkg::word_t rdat2
);

  mipsPkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int idx = 0; idx < 32; idx++) begin
        regs[idx] <= '0;
      end
    end else if (wen && (wsel != 5'd0)) begin
      regs[wsel] <= wdat;  // Register zero never written
    end
  end

  // Reads are combinational
  assign rdat1 = (rsel1 == 5'd0) ? '0 : regs[rsel1];
  assign rdat2 = (rsel2 == 5'd0) ? '0 : regs[rsel2];

endmodule

/* src/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
  input  mipsPkg::instr_t instr,
  input  logic            iHit,
  input  logic            dHit,
  output mipsPkg::ctrl_t  ctrl
);

  always_comb begin
    ctrl       = '0;
    ctrl.aluOp = mipsPkg::ALU_ADD;

    if (instr.r.opcode == mipsPkg::RTYPE) begin
      ctrl.regDst = 1'b1;
      ctrl.wen    = iHit;

      case (instr.r.funct)
        mipsPkg::SLL: begin
          ctrl.aluOp    = mipsPkg::ALU_SLL;
          ctrl.shiftSel = 1'b1;
        end
        mipsPkg::SRL: begin
          ctrl.aluOp    = mipsPkg::ALU_SRL;
          ctrl.shiftSel = 1'b1;
        end
        mipsPkg::JR: begin
          ctrl.wen    = 1'b0;
          ctrl.jmpReg = 1'b1;
        end
        // No overflow traps, so signed and unsigned add/sub match
        mipsPkg::ADD, mipsPkg::ADDU:
          ctrl.aluOp = mipsPkg::ALU_ADD;
        mipsPkg::SUB, mipsPkg::SUBU:
          ctrl.aluOp = mipsPkg::ALU_SUB;
        mipsPkg::AND:  ctrl.aluOp = mipsPkg::ALU_AND;
        mipsPkg::OR:   ctrl.aluOp = mipsPkg::ALU_OR;
        mipsPkg::XOR:  ctrl.aluOp = mipsPkg::ALU_XOR;
        mipsPkg::NOR:  ctrl.aluOp = mipsPkg::ALU_NOR;
        mipsPkg::SLT:  ctrl.aluOp = mipsPkg::ALU_SLT;
        mipsPkg::SLTU: ctrl.aluOp = mipsPkg::ALU_SLTU;
        default:
          ctrl.wen = 1'b0;  // Unknown funct acts as no-op
      endcase
    end else begin
      // I and J formats take the immediate path by default
      ctrl.aluSrc = 1'b1;

      case (instr.i.opcode)
        mipsPkg::ADDI, mipsPkg::ADDIU: begin
          ctrl.wen = iHit;
        end
        mipsPkg::ANDI: begin
          ctrl.wen     = iHit;
          ctrl.aluOp   = mipsPkg::ALU_AND;
          ctrl.zeroExt = 1'b1;
        end
        mipsPkg::ORI: begin
          ctrl.wen     = iHit;
          ctrl.aluOp   = mipsPkg::ALU_OR;
          ctrl.zeroExt = 1'b1;
        end
        mipsPkg::XORI: begin
          ctrl.wen     = iHit;
          ctrl.aluOp   = mipsPkg::ALU_XOR;
          ctrl.zeroExt = 1'b1;
        end
        mipsPkg::SLTI: begin
          ctrl.wen   = iHit;
          ctrl.aluOp = mipsPkg::ALU_SLT;
        end
        mipsPkg::SLTIU: begin
          ctrl.wen   = iHit;
          ctrl.aluOp = mipsPkg::ALU_SLTU;  // Unsigned compare of the sign-extended immediate
        end
        mipsPkg::LUI: begin
          ctrl.wen = iHit;
          ctrl.lui = 1'b1;
        end
        mipsPkg::LW: begin
          ctrl.memToReg = 1'b1;
          ctrl.dRen     = iHit;
          ctrl.wen      = iHit && dHit;  // Write only with the load data
        end
        mipsPkg::SW: begin
          ctrl.dWen = iHit;
        end
        mipsPkg::BEQ: begin
          ctrl.branch = 1'b1;
          ctrl.aluSrc = 1'b0;
          ctrl.aluOp  = mipsPkg::ALU_SUB;
        end
        mipsPkg::BNE: begin
          ctrl.branch = 1'b1;
          ctrl.bne    = 1'b1;
          ctrl.aluSrc = 1'b0;
          ctrl.aluOp  = mipsPkg::ALU_SUB;
        end
        mipsPkg::J: begin
          ctrl.jmp = 1'b1;
        end
        mipsPkg::JAL: begin
          ctrl.jmp = 1'b1;
          ctrl.jl  = 1'b1;
          ctrl.wen = iHit;
        end
        mipsPkg::HALT: begin
          ctrl.halt = 1'b1;
        end
        mipsPkg::LL, mipsPkg::SC: begin
          ctrl.aluSrc = 1'b0;  // Not implemented
        end
        default: begin
          ctrl.aluSrc = 1'b0;
        end
      endcase
    end
  end

endmodule

/* src/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
  input  logic            clk,
  input  logic            rstN,
  input  logic            iHit,
  input  logic            dHit,
  input  mipsPkg::ctrl_t  ctrl,
  input  mipsPkg::instr_t instr,
  input  mipsPkg::word_t  rsData,
  input  logic            zero,
  output mipsPkg::word_t  pc,
  output mipsPkg::word_t  pcPlus4,
  output logic            halt
);

  logic           retire;
  logic           taken;
  mipsPkg::word_t branchTarget;
  mipsPkg::word_t jumpTarget;
  mipsPkg::word_t nextPc;

  // Instruction is done once fetch and any data access have completed
  assign retire = iHit && (!(ctrl.dRen || ctrl.dWen) || dHit) && !halt;

  assign pcPlus4      = pc + 32'd4;
  assign taken        = ctrl.branch && (ctrl.bne ? !zero : zero);
  assign branchTarget = pcPlus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
  assign jumpTarget   = {pcPlus4[31:28], instr.j.addr, 2'b00};

  always_comb begin
    if (ctrl.halt)
      nextPc = pc;  // Park on the HALT word
    else if (ctrl.jmpReg)
      nextPc = rsData;
    else if (ctrl.jmp)
      nextPc = jumpTarget;
    else if (taken)
      nextPc = branchTarget;
    else
      nextPc = pcPlus4;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc   <= mipsPkg::RESET_PC;
      halt <= 1'b0;
    end else if (retire) begin
      pc <= nextPc;
      if (ctrl.halt)
        halt <= 1'b1;  // Sticky until reset
    end
  end

endmodule

/* src/mipsPkg.sv */
package mipsPkg;

  typedef logic [31:0] word_t;

  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDI  = 6'h08,
    ADDIU = 6'h09,
    SLTI  = 6'h0A,
    SLTIU = 6'h0B,
    ANDI  = 6'h0C,
    ORI   = 6'h0D,
    XORI  = 6'h0E,
    LUI   = 6'h0F,
    LW    = 6'h23,
    SW    = 6'h2B,
    LL    = 6'h30,  // Reserved and decoded as no-op
    SC    = 6'h38,  // Reserved and decoded as no-op
    HALT  = 6'h3F
  } opcode_t;

  typedef enum logic [5:0] {
    SLL  = 6'h00,
    SRL  = 6'h02,
    JR   = 6'h08,
    ADD  = 6'h20,
    ADDU = 6'h21,
    SUB  = 6'h22,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    NOR  = 6'h27,
    SLT  = 6'h2A,
    SLTU = 6'h2B
  } funct_t;

  typedef enum logic [3:0] {
    ALU_SLL,
    ALU_SRL,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU
  } aluOp_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    funct_t      funct;
  } rType_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iType_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] addr;
  } jType_t;

  // Same 32-bit word seen through each format
  typedef union packed {
    rType_t r;
    iType_t i;
    jType_t j;
  } instr_t;

  typedef struct packed {
    logic   regDst;    // Write rd instead of rt
    logic   branch;
    logic   bne;
    logic   wen;
    logic   aluSrc;    // Immediate as operand B
    logic   shiftSel;  // Shamt as operand B
    logic   memToReg;
    logic   dRen;
    logic   dWen;
    logic   jmp;
    logic   jl;        // Link into register 31
    logic   jmpReg;
    logic   zeroExt;
    logic   lui;
    logic   halt;
    aluOp_t aluOp;
  } ctrl_t;

  localparam word_t      RESET_PC = 32'h0000_0000;
  localparam logic [4:0] LINK_REG = 5'd31;

endpackage
